/* data_sram.sv */
// byte-writable data sram
`timescale 1ns/1ps

module data_sram #(
    parameter int DEPTH_WORDS = 256
) (
    input logic clk,
    sram_if.mem mem
);

    localparam int XLEN  = lsu_pkg::XLEN;
    localparam int LANES = XLEN / 8;

    // word array, contents undefined until written
    logic [XLEN-1:0] ram [DEPTH_WORDS];
    logic [XLEN-1:0] rdata_q;

    // write path
    // only lanes with their strobe bit set are updated
    always_ff @(posedge clk) begin
        if (mem.en && mem.we) begin
            for (int b = 0; b < LANES; b++) begin
                if (mem.wstrb[b]) begin
                    ram[mem.index][b*8 +: 8] <= mem.wdata[b*8 +: 8];
                end
            end
        end
    end

    // read path, one cycle latency
    // holds its value until the next read
    always_ff @(posedge clk) begin
        if (mem.en && !mem.we) begin
            rdata_q <= ram[mem.index];
        end
    end

    assign mem.rdata = rdata_q;

endmodule

/* lsu.f */
lsu_pkg.sv
sram_if.sv
lsu_align.sv
data_sram.sv
lsu_ctrl.sv
lsu_top.sv
tb_lsu.sv

/* lsu_align.sv */
// load/store lane alignment
`timescale 1ns/1ps

module lsu_align (
    input  logic [1:0]                lane_i,
    input  lsu_pkg::store_type_e      store_type_i,
    input  logic [lsu_pkg::XLEN-1:0]  store_data_i,
    input  lsu_pkg::load_type_e       load_type_i,
    input  logic [lsu_pkg::XLEN-1:0]  rdata_i,
    output logic [3:0]                strobe_o,
    output logic [lsu_pkg::XLEN-1:0]  placed_data_o,
    output logic [lsu_pkg::XLEN-1:0]  load_value_o
);

    localparam int XLEN = lsu_pkg::XLEN;

    logic [7:0]  sel_byte;
    logic [15:0] sel_half;

    // store side
    // data is replicated so every lane carries it, strobe picks the lanes
    always_comb begin
        case (store_type_i)
            lsu_pkg::STORE_SB: begin
                placed_data_o = {4{store_data_i[7:0]}};
                strobe_o      = 4'b0001 << lane_i;
            end
            lsu_pkg::STORE_SH: begin
                placed_data_o = {2{store_data_i[15:0]}};
                // bit 0 of the lane is ignored for halfwords
                strobe_o      = lane_i[1] ? 4'b1100 : 4'b0011;
            end
            lsu_pkg::STORE_SW: begin
                placed_data_o = store_data_i;
                strobe_o      = 4'b1111;
            end
            default: begin
                placed_data_o = store_data_i;
                strobe_o      = 4'b0000;
            end
        endcase
    end

    // load side, byte pick by both lane bits
    always_comb begin
        case (lane_i)
            2'd0:    sel_byte = rdata_i[7:0];
            2'd1:    sel_byte = rdata_i[15:8];
            2'd2:    sel_byte = rdata_i[23:16];
            default: sel_byte = rdata_i[31:24];
        endcase
    end

    // halfword pick uses the upper lane bit only
    assign sel_half = lane_i[1] ? rdata_i[31:16] : rdata_i[15:0];

    always_comb begin
        case (load_type_i)
            lsu_pkg::LOAD_LB: begin
                load_value_o = {{(XLEN-8){sel_byte[7]}}, sel_byte};
            end
            lsu_pkg::LOAD_LH: begin
                load_value_o = {{(XLEN-16){sel_half[15]}}, sel_half};
            end
            lsu_pkg::LOAD_LBU: begin
                load_value_o = {{(XLEN-8){1'b0}}, sel_byte};
            end
            lsu_pkg::LOAD_LHU: begin
                load_value_o = {{(XLEN-16){1'b0}}, sel_half};
            end
            default: begin
                // word load passes the raw word
                load_value_o = rdata_i;
            end
        endcase
    end

endmodule

/* lsu_ctrl.sv */
// load/store unit controller
`timescale 1ns/1ps

module lsu_ctrl #(
    parameter int DEPTH_WORDS = 256
) (
    input  logic                      clk,
    input  logic                      rst,
    // request side
    input  logic                      req_valid_i,
    output logic                      req_ready_o,
    input  logic [lsu_pkg::XLEN-1:0]  addr_i,
    input  logic [lsu_pkg::XLEN-1:0]  alu_result_i,
    input  logic [lsu_pkg::XLEN-1:0]  store_data_i,
    input  lsu_pkg::mem_op_e          mem_op_i,
    input  lsu_pkg::load_type_e       load_type_i,
    input  lsu_pkg::store_type_e      store_type_i,
    input  logic                      wd_i,
    input  logic [4:0]                wreg_i,
    input  logic [lsu_pkg::XLEN-1:0]  csr_wdata_i,
    // writeback side
    output logic                      wb_valid_o,
    input  logic                      wb_ready_i,
    output logic                      wb_wd_o,
    output logic [4:0]                wb_wreg_o,
    output logic [lsu_pkg::XLEN-1:0]  wb_wdata_o,
    output logic [lsu_pkg::XLEN-1:0]  wb_csr_wdata_o,
    // memory access
    sram_if.ctrl                      mem,
    // aligner
    output logic [1:0]                lane_o,
    output lsu_pkg::store_type_e      store_type_o,
    output lsu_pkg::load_type_e       load_type_o,
    output logic [lsu_pkg::XLEN-1:0]  store_data_o,
    output logic [lsu_pkg::XLEN-1:0]  rdata_o,
    input  logic [3:0]                strobe_i,
    input  logic [lsu_pkg::XLEN-1:0]  placed_data_i,
    input  logic [lsu_pkg::XLEN-1:0]  load_value_i
);

    localparam int IDX_W = $clog2(DEPTH_WORDS);

    lsu_pkg::lsu_state_e state_q;
    lsu_pkg::lsu_state_e state_d;

    // latched request payload
    logic [IDX_W+1:0]             addr_q;
    logic [lsu_pkg::XLEN-1:0]     alu_q;
    logic [lsu_pkg::XLEN-1:0]     store_data_q;
    lsu_pkg::mem_op_e             op_q;
    lsu_pkg::load_type_e          load_type_q;
    lsu_pkg::store_type_e         store_type_q;
    logic                         wd_q;
    logic [4:0]                   wreg_q;
    logic [lsu_pkg::XLEN-1:0]     csr_q;

    logic accept;

    assign req_ready_o = (state_q == lsu_pkg::ST_IDLE);
    assign accept      = req_valid_i && req_ready_o;

    always_comb begin
        state_d = state_q;
        case (state_q)
            lsu_pkg::ST_IDLE: begin
                if (accept) begin
                    state_d = lsu_pkg::ST_ACCESS;
                end
            end
            // access always takes exactly one cycle
            lsu_pkg::ST_ACCESS: state_d = lsu_pkg::ST_RESP;
            lsu_pkg::ST_RESP: begin
                if (wb_ready_i) begin
                    state_d = lsu_pkg::ST_IDLE;
                end
            end
            default: state_d = lsu_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= lsu_pkg::ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // payload only changes on acceptance, so the response stays stable
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q       <= addr_i[IDX_W+1:0];
            alu_q        <= alu_result_i;
            store_data_q <= store_data_i;
            op_q         <= mem_op_i;
            load_type_q  <= load_type_i;
            store_type_q <= store_type_i;
            wd_q         <= wd_i;
            wreg_q       <= wreg_i;
            csr_q        <= csr_wdata_i;
        end
    end

    // sram drive, word index wraps at the memory depth
    assign mem.en    = (state_q == lsu_pkg::ST_ACCESS) && (op_q != lsu_pkg::MEM_NONE);
    assign mem.we    = (op_q == lsu_pkg::MEM_STORE);
    assign mem.index = addr_q[IDX_W+1:2];
    assign mem.wstrb = strobe_i;
    assign mem.wdata = placed_data_i;

    // aligner feed
    assign lane_o       = addr_q[1:0];
    assign store_type_o = store_type_q;
    assign load_type_o  = load_type_q;
    assign store_data_o = store_data_q;
    assign rdata_o      = mem.rdata;

    // writeback
    assign wb_valid_o     = (state_q == lsu_pkg::ST_RESP);
    assign wb_wd_o        = wd_q;
    assign wb_wreg_o      = wreg_q;
    assign wb_csr_wdata_o = csr_q;
    assign wb_wdata_o     = (op_q == lsu_pkg::MEM_LOAD) ? load_value_i : alu_q;

endmodule

/* lsu_pkg.sv */
// load/store unit shared types
package lsu_pkg;

    // data and address width
    localparam int XLEN = 32;

    // operation class of an execute-stage result
    typedef enum logic [1:0] {
        MEM_NONE  = 2'd0,
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2
    } mem_op_e;

    // load kind, signed and unsigned variants
    typedef enum logic [2:0] {
        LOAD_LB  = 3'd0,
        LOAD_LH  = 3'd1,
        LOAD_LW  = 3'd2,
        LOAD_LBU = 3'd3,
        LOAD_LHU = 3'd4
    } load_type_e;

    // store size
    typedef enum logic [1:0] {
        STORE_SB = 2'd0,
        STORE_SH = 2'd1,
        STORE_SW = 2'd2
    } store_type_e;

    // controller state
    // one request in flight at a time
    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_ACCESS = 2'd1,
        ST_RESP   = 2'd2
    } lsu_state_e;

endpackage

/* lsu_tests.txt */
# op type addr store_data alu_result expected_wb_wdata, all hex
# op 0 none, 1 load, 2 store; type is the load kind for loads, the store size for stores
0 0 00000000 00000000 12345678 12345678
0 0 0000ffff cafef00d deadbeef deadbeef
2 2 00000010 a1b2c3d4 00000000 00000000
1 2 00000010 00000000 00000000 a1b2c3d4
2 2 00000020 11223344 00000055 00000055
2 0 00000020 123456aa 00000000 00000000
1 2 00000020 00000000 00000000 112233aa
2 0 00000021 000000bb 00000000 00000000
1 2 00000020 00000000 00000000 1122bbaa
2 0 00000022 000000cc 00000000 00000000
1 2 00000020 00000000 00000000 11ccbbaa
2 0 00000023 000000dd 00000000 00000000
1 2 00000020 00000000 77777777 ddccbbaa
1 0 00000020 00000000 00000000 ffffffaa
1 0 00000021 00000000 00000000 ffffffbb
1 0 00000022 00000000 00000000 ffffffcc
1 0 00000023 00000000 00000000 ffffffdd
1 3 00000022 00000000 00000000 000000cc
1 3 00000023 00000000 00000000 000000dd
1 1 00000020 00000000 00000000 ffffbbaa
1 1 00000021 00000000 00000000 ffffbbaa
1 1 00000022 00000000 00000000 ffffddcc
1 4 00000022 00000000 00000000 0000ddcc
1 4 00000020 00000000 00000000 0000bbaa
2 2 00000030 7f0a7f0a 00000000 00000000
1 0 00000030 00000000 00000000 0000000a
1 0 00000031 00000000 00000000 0000007f
1 1 00000032 00000000 00000000 00007f0a
1 3 00000031 00000000 00000000 0000007f
2 2 00000034 12345678 00000000 00000000
2 1 00000036 9999beef 00000000 00000000
1 2 00000034 00000000 00000000 beef5678
1 4 00000036 00000000 00000000 0000beef
1 1 00000035 00000000 00000000 00005678
2 2 00000043 01020304 00000000 00000000
1 2 00000040 00000000 00000000 01020304
1 2 00000410 00000000 00000000 a1b2c3d4
0 0 00000020 00000000 0badf00d 0badf00d

/* lsu_top.sv */
// load/store unit top level
`timescale 1ns/1ps

module lsu_top #(
    parameter int DEPTH_WORDS = 256
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      req_valid_i,
    output logic                      req_ready_o,
    input  logic [lsu_pkg::XLEN-1:0]  addr_i,
    input  logic [lsu_pkg::XLEN-1:0]  alu_result_i,
    input  logic [lsu_pkg::XLEN-1:0]  store_data_i,
    input  lsu_pkg::mem_op_e          mem_op_i,
    input  lsu_pkg::load_type_e       load_type_i,
    input  lsu_pkg::store_type_e      store_type_i,
    input  logic                      wd_i,
    input  logic [4:0]                wreg_i,
    input  logic [lsu_pkg::XLEN-1:0]  csr_wdata_i,
    output logic                      wb_valid_o,
    input  logic                      wb_ready_i,
    output logic                      wb_wd_o,
    output logic [4:0]                wb_wreg_o,
    output logic [lsu_pkg::XLEN-1:0]  wb_wdata_o,
    output logic [lsu_pkg::XLEN-1:0]  wb_csr_wdata_o
);

    // controller to aligner
    logic [1:0]                lane;
    lsu_pkg::store_type_e      store_type;
    lsu_pkg::load_type_e       load_type;
    logic [lsu_pkg::XLEN-1:0]  store_data;
    logic [lsu_pkg::XLEN-1:0]  rdata;
    // aligner to controller
    logic [3:0]                strobe;
    logic [lsu_pkg::XLEN-1:0]  placed_data;
    logic [lsu_pkg::XLEN-1:0]  load_value;

    sram_if #(.DEPTH_WORDS(DEPTH_WORDS)) sram ();

    lsu_ctrl #(
        .DEPTH_WORDS (DEPTH_WORDS)
    ) i_ctrl (
        .clk            (clk),
        .rst            (rst),
        .req_valid_i    (req_valid_i),
        .req_ready_o    (req_ready_o),
        .addr_i         (addr_i),
        .alu_result_i   (alu_result_i),
        .store_data_i   (store_data_i),
        .mem_op_i       (mem_op_i),
        .load_type_i    (load_type_i),
        .store_type_i   (store_type_i),
        .wd_i           (wd_i),
        .wreg_i         (wreg_i),
        .csr_wdata_i    (csr_wdata_i),
        .wb_valid_o     (wb_valid_o),
        .wb_ready_i     (wb_ready_i),
        .wb_wd_o        (wb_wd_o),
        .wb_wreg_o      (wb_wreg_o),
        .wb_wdata_o     (wb_wdata_o),
        .wb_csr_wdata_o (wb_csr_wdata_o),
        .mem            (sram.ctrl),
        .lane_o         (lane),
        .store_type_o   (store_type),
        .load_type_o    (load_type),
        .store_data_o   (store_data),
        .rdata_o        (rdata),
        .strobe_i       (strobe),
        .placed_data_i  (placed_data),
        .load_value_i   (load_value)
    );

    lsu_align i_align (
        .lane_i        (lane),
        .store_type_i  (store_type),
        .store_data_i  (store_data),
        .load_type_i   (load_type),
        .rdata_i       (rdata),
        .strobe_o      (strobe),
        .placed_data_o (placed_data),
        .load_value_o  (load_value)
    );

    data_sram #(
        .DEPTH_WORDS (DEPTH_WORDS)
    ) i_sram (
        .clk (clk),
        .mem (sram.mem)
    );

endmodule

/* run.sh */
#!/bin/sh
# build and run the load/store unit testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_lsu -f lsu.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_lsu)
status=$?
printf '%s\n' "$out"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# pass only when the testbench reported a clean run
if printf '%s\n' "$out" | grep -qx "Done: no errors"; then
    exit 0
fi
exit 1

/* sram_if.sv */
// data sram access interface
`timescale 1ns/1ps

interface sram_if #(
    parameter int DEPTH_WORDS = 256
);
    localparam int IDX_W = $clog2(DEPTH_WORDS);

    // access strobe and direction
    logic                      en;
    logic                      we;
    logic [IDX_W-1:0]          index;
    // byte lanes to write
    logic [3:0]                wstrb;
    logic [lsu_pkg::XLEN-1:0]  wdata;
    // raw word, valid the cycle after a read
    logic [lsu_pkg::XLEN-1:0]  rdata;

    modport ctrl (
        output en, we, index, wstrb, wdata,
        input  rdata
    );

    modport mem (
        input  en, we, index, wstrb, wdata,
        output rdata
    );

endinterface

/* tb_lsu.sv */
// load/store unit testbench
`timescale 1ns/1ps

module tb_lsu;

    logic                  clk;
    logic                  rst;
    logic                  req_valid_i;
    logic                  req_ready_o;
    logic [31:0]           addr_i;
    logic [31:0]           alu_result_i;
    logic [31:0]           store_data_i;
    lsu_pkg::mem_op_e      mem_op_i;
    lsu_pkg::load_type_e   load_type_i;
    lsu_pkg::store_type_e  store_type_i;
    logic                  wd_i;
    logic [4:0]            wreg_i;
    logic [31:0]           csr_wdata_i;
    logic                  wb_valid_o;
    logic                  wb_ready_i;
    logic                  wb_wd_o;
    logic [4:0]            wb_wreg_o;
    logic [31:0]           wb_wdata_o;
    logic [31:0]           wb_csr_wdata_o;

    // one entry per test line
    logic [3:0]  q_op[$];
    logic [3:0]  q_type[$];
    logic [31:0] q_addr[$];
    logic [31:0] q_sdata[$];
    logic [31:0] q_alu[$];
    logic [31:0] q_exp[$];

    int num_tests = 0;
    int errors = 0;
    int test_errs = 0;
    int failed_tests = 0;

    lsu_top #(.DEPTH_WORDS(256)) i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // lines starting with # are column notes
    task automatic read_tests();
        int fd;
        int n;
        string line;
        logic [3:0] op;
        logic [3:0] typ;
        logic [31:0] addr;
        logic [31:0] sdata;
        logic [31:0] alu;
        logic [31:0] expv;
        fd = $fopen("lsu_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open lsu_tests.txt");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) == 0) break;
            if (line.len() < 2 || line.getc(0) == "#") continue;
            n = $sscanf(line, "%h %h %h %h %h %h", op, typ, addr, sdata, alu, expv);
            if (n == 6) begin
                q_op.push_back(op);
                q_type.push_back(typ);
                q_addr.push_back(addr);
                q_sdata.push_back(sdata);
                q_alu.push_back(alu);
                q_exp.push_back(expv);
            end
        end
        $fclose(fd);
        num_tests = q_op.size();
    endtask

    // compare every writeback field with the expected response
    task automatic check_response(input logic [31:0] exp_wdata, input logic exp_wd,
                                  input logic [4:0] exp_wreg, input logic [31:0] exp_csr);
        if (wb_wdata_o !== exp_wdata) begin
            $display("mismatch wb_wdata_o: got %h expected %h", wb_wdata_o, exp_wdata);
            test_errs++;
        end
        if (wb_wd_o !== exp_wd) begin
            $display("mismatch wb_wd_o: got %h expected %h", wb_wd_o, exp_wd);
            test_errs++;
        end
        if (wb_wreg_o !== exp_wreg) begin
            $display("mismatch wb_wreg_o: got %h expected %h", wb_wreg_o, exp_wreg);
            test_errs++;
        end
        if (wb_csr_wdata_o !== exp_csr) begin
            $display("mismatch wb_csr_wdata_o: got %h expected %h", wb_csr_wdata_o, exp_csr);
            test_errs++;
        end
    endtask

    // new random payload while req_valid_i is low
    task automatic scramble_payload();
        logic [31:0] rnd;
        rnd          = $urandom;
        addr_i       = $urandom;
        alu_result_i = $urandom;
        store_data_i = $urandom;
        wd_i         = rnd[5];
        wreg_i       = rnd[4:0];
        csr_wdata_i  = $urandom;
    endtask

    task automatic run_test(input int idx);
        logic [31:0] rnd;
        logic        exp_wd;
        logic [4:0]  exp_wreg;
        logic [31:0] exp_csr;
        string       verdict;
        int stall;
        test_errs = 0;
        rnd      = $urandom;
        exp_wd   = rnd[5];
        exp_wreg = rnd[4:0];
        exp_csr  = $urandom;
        @(negedge clk);
        req_valid_i  = 1'b1;
        addr_i       = q_addr[idx];
        alu_result_i = q_alu[idx];
        store_data_i = q_sdata[idx];
        mem_op_i     = lsu_pkg::mem_op_e'(q_op[idx][1:0]);
        load_type_i  = lsu_pkg::load_type_e'(q_type[idx][2:0]);
        store_type_i = lsu_pkg::store_type_e'(q_type[idx][1:0]);
        wd_i         = exp_wd;
        wreg_i       = exp_wreg;
        csr_wdata_i  = exp_csr;
        while (!req_ready_o) @(negedge clk);
        // accepting edge
        @(posedge clk);
        @(negedge clk);
        req_valid_i = 1'b0;
        // the response must come from the latched payload
        scramble_payload();
        if (wb_valid_o !== 1'b0 || req_ready_o !== 1'b0) begin
            $display("handshake wrong one edge after acceptance");
            test_errs++;
        end
        @(negedge clk);
        if (wb_valid_o !== 1'b1) begin
            $display("wb_valid_o not high two edges after acceptance");
            test_errs++;
            while (wb_valid_o !== 1'b1) @(negedge clk);
        end
        if (req_ready_o !== 1'b0) begin
            $display("req_ready_o high while a response is pending");
            test_errs++;
        end
        check_response(q_exp[idx], exp_wd, exp_wreg, exp_csr);
        // back-pressure holds the response until taken
        stall = $urandom_range(3, 0);
        repeat (stall) begin
            @(negedge clk);
            if (wb_valid_o !== 1'b1 || req_ready_o !== 1'b0) begin
                $display("handshake changed while the response was stalled");
                test_errs++;
            end
            check_response(q_exp[idx], exp_wd, exp_wreg, exp_csr);
        end
        wb_ready_i = 1'b1;
        @(negedge clk);
        wb_ready_i = 1'b0;
        if (wb_valid_o !== 1'b0 || req_ready_o !== 1'b1) begin
            $display("unit did not return to idle after the response transfer");
            test_errs++;
        end
        verdict = (test_errs == 0) ? "ok" : "failed";
        $display("test %0d op %0h type %0h addr %h stall %0d: %s", idx, q_op[idx],
                 q_type[idx], q_addr[idx], stall, verdict);
        errors += test_errs;
        if (test_errs != 0) failed_tests++;
    endtask

    // watchdog scaled to the number of tests
    initial begin
        wait (num_tests > 0);
        repeat (num_tests * 40) @(posedge clk);
        $display("timeout after %0d cycles, tests did not finish", num_tests * 40);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        rst          = 1'b1;
        req_valid_i  = 1'b0;
        addr_i       = '0;
        alu_result_i = '0;
        store_data_i = '0;
        mem_op_i     = lsu_pkg::MEM_NONE;
        load_type_i  = lsu_pkg::LOAD_LB;
        store_type_i = lsu_pkg::STORE_SB;
        wd_i         = 1'b0;
        wreg_i       = '0;
        csr_wdata_i  = '0;
        wb_ready_i   = 1'b0;
        void'($urandom(32'haa8d));
        read_tests();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        if (req_ready_o !== 1'b1 || wb_valid_o !== 1'b0) begin
            $display("idle handshake wrong right after reset");
            errors++;
        end
        if (num_tests == 0) begin
            $display("no tests were read");
            errors++;
        end
        for (int i = 0; i < num_tests; i++) begin
            run_test(i);
        end
        $display("tests %0d, failed %0d, errors %0d", num_tests, failed_tests, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
